//--- design/fetch_pkg.sv
package fetch_pkg;

	// ******************************
	// widths
	// ******************************

	// pc, addresses and memory words
	localparam int xlen = 64;
	// one instruction
	localparam int ilen = 32;

	// ******************************
	// rv64 major opcodes
	// ******************************

	// beq bne blt bge bltu bgeu
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;

	// what the ifu sees in the fetched word
	typedef enum logic [1:0] {
		none,
		cond_branch,
		jump
	} branch_kind_e;

	// encoding follows the funct3 of the load opcode
	typedef enum logic [2:0] {
		lb  = 3'd0,
		lh  = 3'd1,
		lw  = 3'd2,
		ld  = 3'd3,
		lbu = 3'd4,
		lhu = 3'd5,
		lwu = 3'd6
	} load_op_e;

	// load unit sequence
	typedef enum logic [1:0] {
		idle,
		access,
		done
	} lsu_state_e;

endpackage

//--- design/mem_if.sv
`timescale 1ns/1ps

// one requester's read path into the arbiter
interface mem_if;

	// request level, held while waiting
	logic                      req;
	// byte address of the wanted word
	logic [fetch_pkg::xlen-1:0] addr;
	// this requester owns the port this cycle
	logic                      gnt;
	// valid in the same cycle as req and gnt
	logic [fetch_pkg::xlen-1:0] rdata;

	// seen from the ifu or lsu side
	modport requester (
		output req,
		output addr,
		input  gnt,
		input  rdata
	);

	// seen from the arbiter side
	modport arbiter (
		input  req,
		input  addr,
		output gnt,
		output rdata
	);

endinterface

//--- design/ifu.sv
`timescale 1ns/1ps

module ifu #(
	parameter logic [fetch_pkg::xlen-1:0] reset_pc = 64'h8000_0000
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [fetch_pkg::xlen-1:0] dnpc,
	input  logic                       pc_update,
	input  logic                       ready_if_id,
	output logic                       valid_if_id,
	output logic [fetch_pkg::xlen-1:0] pc,
	output logic [fetch_pkg::ilen-1:0] inst,
	output logic                       branch_flush,
	mem_if.requester                   mem
);

	logic [fetch_pkg::xlen-1:0] pc_q;
	logic [fetch_pkg::xlen-1:0] pc_next;
	logic [fetch_pkg::xlen-1:0] imm_b;
	logic [fetch_pkg::xlen-1:0] imm_j;
	fetch_pkg::branch_kind_e    kind;

	// ******************************
	// fetch request
	// ******************************

	// always asking even when the lsu takes the port
	assign mem.req  = 1'b1;
	assign mem.addr = pc_q;

	// pc bit 2 picks the half of the 64-bit word
	assign inst = pc_q[2] ? mem.rdata[63:32] : mem.rdata[31:0];

	assign pc           = pc_q;
	assign valid_if_id  = mem.gnt;
	assign branch_flush = pc_update;

	// ******************************
	// branch detection
	// ******************************

	always_comb begin
		kind = fetch_pkg::none;
		if (inst[6:0] == fetch_pkg::opc_jal) begin
			kind = fetch_pkg::jump;
		end else if (inst[6:0] == fetch_pkg::opc_branch) begin
			// funct3 010 and 011 are not branches
			case (inst[14:12])
				3'b010, 3'b011: kind = fetch_pkg::none;
				default:        kind = fetch_pkg::cond_branch;
			endcase
		end
	end

	// b-type offset with its sign from bit 31
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	// j-type offset
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// ******************************
	// next pc
	// ******************************

	always_comb begin
		if (pc_update) begin
			// redirect beats stall
			pc_next = dnpc;
		end else if (!ready_if_id || !mem.gnt) begin
			// decode full or port lost to lsu
			pc_next = pc_q;
		end else if (kind == fetch_pkg::cond_branch && inst[31]) begin
			// backward branch predicted taken
			pc_next = pc_q + imm_b;
		end else if (kind == fetch_pkg::jump && inst[31]) begin
			pc_next = pc_q + imm_j;
		end else begin
			pc_next = pc_q + 64'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= reset_pc;
		end else begin
			pc_q <= pc_next;
		end
	end

endmodule

//--- design/lsu.sv
`timescale 1ns/1ps

module lsu (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ld_req,
	input  logic [2:0]                 ld_op,
	input  logic [fetch_pkg::xlen-1:0] ld_addr,
	output logic                       ld_busy,
	output logic                       ld_done,
	output logic [fetch_pkg::xlen-1:0] ld_data,
	mem_if.requester                   mem
);

	fetch_pkg::lsu_state_e      state;
	fetch_pkg::load_op_e        op_q;
	logic [fetch_pkg::xlen-1:0] addr_q;
	logic [5:0]                 shamt;
	logic [fetch_pkg::xlen-1:0] shifted;
	logic [fetch_pkg::xlen-1:0] load_val;

	// only the access cycle goes to memory
	assign mem.req  = (state == fetch_pkg::access);
	assign mem.addr = addr_q;

	assign ld_busy = (state != fetch_pkg::idle);
	assign ld_done = (state == fetch_pkg::done);

	// ******************************
	// sizing and extension
	// ******************************

	always_comb begin
		// low bits under the access size dropped
		case (op_q)
			fetch_pkg::lb, fetch_pkg::lbu: shamt = {addr_q[2:0], 3'b000};
			fetch_pkg::lh, fetch_pkg::lhu: shamt = {addr_q[2:1], 4'b0000};
			fetch_pkg::lw, fetch_pkg::lwu: shamt = {addr_q[2], 5'b00000};
			default:                       shamt = 6'd0;
		endcase
		shifted = mem.rdata >> shamt;
		case (op_q)
			fetch_pkg::lb:  load_val = {{56{shifted[7]}}, shifted[7:0]};
			fetch_pkg::lh:  load_val = {{48{shifted[15]}}, shifted[15:0]};
			fetch_pkg::lw:  load_val = {{32{shifted[31]}}, shifted[31:0]};
			fetch_pkg::lbu: load_val = {56'd0, shifted[7:0]};
			fetch_pkg::lhu: load_val = {48'd0, shifted[15:0]};
			fetch_pkg::lwu: load_val = {32'd0, shifted[31:0]};
			default:        load_val = shifted;
		endcase
	end

	// ******************************
	// fsm
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_pkg::idle;
		end else begin
			case (state)
				fetch_pkg::idle:   if (ld_req) state <= fetch_pkg::access;
				fetch_pkg::access: if (mem.gnt) state <= fetch_pkg::done;
				default:           state <= fetch_pkg::idle;
			endcase
		end
	end

	// request payload taken in idle only
	always_ff @(posedge clk) begin
		if (state == fetch_pkg::idle && ld_req) begin
			op_q   <= fetch_pkg::load_op_e'(ld_op);
			addr_q <= ld_addr;
		end
		if (state == fetch_pkg::access && mem.gnt) begin
			ld_data <= load_val;
		end
	end

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	mem_if.arbiter                     lsu_port,
	mem_if.arbiter                     ifu_port,
	output logic [fetch_pkg::xlen-1:0] mem_addr,
	input  logic [fetch_pkg::xlen-1:0] mem_rdata
);

	// ******************************
	// fixed priority with lsu first
	// ******************************

	// lsu never waits
	assign lsu_port.gnt = lsu_port.req;
	// ifu only when the lsu is quiet
	assign ifu_port.gnt = ifu_port.req && !lsu_port.req;

	// address mux
	always_comb begin
		if (lsu_port.req) begin
			mem_addr = lsu_port.addr;
		end else begin
			mem_addr = ifu_port.addr;
		end
	end

	// read data back to the winner only
	assign lsu_port.rdata = lsu_port.gnt ? mem_rdata : '0;
	assign ifu_port.rdata = ifu_port.gnt ? mem_rdata : '0;

endmodule

//--- design/unified_mem.sv
`timescale 1ns/1ps

module unified_mem #(
	parameter int mem_words = 256
) (
	input  logic                       clk,
	input  logic [fetch_pkg::xlen-1:0] rd_addr,
	input  logic                       wr_en,
	input  logic [fetch_pkg::xlen-1:0] wr_addr,
	input  logic [fetch_pkg::xlen-1:0] wr_data,
	output logic [fetch_pkg::xlen-1:0] rd_data
);

	localparam int idx_w = $clog2(mem_words);

	logic [fetch_pkg::xlen-1:0] mem_q [mem_words];
	logic [idx_w-1:0]           rd_idx;
	logic [idx_w-1:0]           wr_idx;

	// word index sits just above the byte offset
	// upper address bits wrap
	assign rd_idx = rd_addr[idx_w+2:3];
	assign wr_idx = wr_addr[idx_w+2:3];

	// ******************************
	// async read, clocked preload
	// ******************************

	assign rd_data = mem_q[rd_idx];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_q[wr_idx] <= wr_data;
		end
	end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter logic [fetch_pkg::xlen-1:0] reset_pc  = 64'h8000_0000,
	parameter int                         mem_words = 256
) (
	input  logic                       clk,
	input  logic                       rst,
	// redirect and decode handshake
	input  logic [fetch_pkg::xlen-1:0] dnpc,
	input  logic                       pc_update,
	input  logic                       ready_if_id,
	output logic                       valid_if_id,
	output logic [fetch_pkg::xlen-1:0] pc,
	output logic [fetch_pkg::ilen-1:0] inst,
	output logic                       branch_flush,
	// load requester
	input  logic                       ld_req,
	input  logic [2:0]                 ld_op,
	input  logic [fetch_pkg::xlen-1:0] ld_addr,
	output logic                       ld_busy,
	output logic                       ld_done,
	output logic [fetch_pkg::xlen-1:0] ld_data,
	// preload port
	input  logic                       wr_en,
	input  logic [fetch_pkg::xlen-1:0] wr_addr,
	input  logic [fetch_pkg::xlen-1:0] wr_data
);

	logic [fetch_pkg::xlen-1:0] mem_addr;
	logic [fetch_pkg::xlen-1:0] mem_rdata;

	// ******************************
	// read paths into the arbiter
	// ******************************

	mem_if if_bus ();
	mem_if ls_bus ();

	ifu #(
		.reset_pc(reset_pc)
	) ifu0 (
		.clk         (clk),
		.rst         (rst),
		.dnpc        (dnpc),
		.pc_update   (pc_update),
		.ready_if_id (ready_if_id),
		.valid_if_id (valid_if_id),
		.pc          (pc),
		.inst        (inst),
		.branch_flush(branch_flush),
		.mem         (if_bus)
	);

	lsu lsu0 (
		.clk    (clk),
		.rst    (rst),
		.ld_req (ld_req),
		.ld_op  (ld_op),
		.ld_addr(ld_addr),
		.ld_busy(ld_busy),
		.ld_done(ld_done),
		.ld_data(ld_data),
		.mem    (ls_bus)
	);

	// lsu wins every conflict
	mem_arbiter arb0 (
		.lsu_port (ls_bus),
		.ifu_port (if_bus),
		.mem_addr (mem_addr),
		.mem_rdata(mem_rdata)
	);

	unified_mem #(
		.mem_words(mem_words)
	) mem0 (
		.clk    (clk),
		.rd_addr(mem_addr),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_data(mem_rdata)
	);

endmodule

//--- include/tb_model.svh
`ifndef tb_model_svh
`define tb_model_svh

// ******************************
// next pc reference
// ******************************

// redirect, then stall, then backward prediction, then pc + 4
function automatic logic [63:0] ref_next_pc(
	input logic [63:0] cur_pc,
	input logic [31:0] word,
	input logic        redirect,
	input logic [63:0] target,
	input logic        stall
);
	logic signed [12:0] off_b;
	logic signed [20:0] off_j;
	logic               is_branch;
	logic               is_jal;
	// funct3 010 and 011 are holes in the branch group
	is_branch = (word[6:0] == fetch_pkg::opc_branch) && (word[14:13] != 2'b01);
	is_jal    = (word[6:0] == fetch_pkg::opc_jal);
	// b and j offsets keep bit 0 at zero
	off_b = {word[31], word[7], word[30:25], word[11:8], 1'b0};
	off_j = {word[31], word[19:12], word[20], word[30:21], 1'b0};
	if (redirect) return target;
	if (stall) return cur_pc;
	// negative offset means taken
	if (is_branch && off_b[12]) return cur_pc + 64'(off_b);
	if (is_jal && off_j[20]) return cur_pc + 64'(off_j);
	return cur_pc + 64'd4;
endfunction

// ******************************
// load result reference
// ******************************

function automatic logic [63:0] ref_load(
	input logic [63:0] word,
	input logic [63:0] addr,
	input logic [2:0]  op
);
	logic [7:0]  b;
	logic [15:0] h;
	logic [31:0] w;
	logic [63:0] v;
	// lane picked by the size-aligned low address bits
	b = word[8 * int'(addr[2:0]) +: 8];
	h = word[16 * int'(addr[2:1]) +: 16];
	w = word[32 * int'(addr[2]) +: 32];
	case (fetch_pkg::load_op_e'(op))
		fetch_pkg::lb:  v = b[7] ? (64'(b) | ~64'hff) : 64'(b);
		fetch_pkg::lh:  v = h[15] ? (64'(h) | ~64'hffff) : 64'(h);
		fetch_pkg::lw:  v = w[31] ? (64'(w) | ~64'hffff_ffff) : 64'(w);
		fetch_pkg::lbu: v = 64'(b);
		fetch_pkg::lhu: v = 64'(h);
		fetch_pkg::lwu: v = 64'(w);
		default:        v = word;
	endcase
	return v;
endfunction

// galois lfsr with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	if (s[0]) return (s >> 1) ^ 16'hb400;
	return s >> 1;
endfunction

`endif

//--- testbench/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

	localparam logic [63:0] reset_pc   = 64'h8000_0000;
	localparam int          mem_words  = 256;
	localparam int          idx_w      = $clog2(mem_words);
	localparam int          clk_period = 40;
	localparam int          n_directed = 200;
	localparam int          n_random   = 400;
	// preload, reset, directed and random cycles
	localparam int          n_cycles   = mem_words + 2 + n_directed + n_random;

	logic        clk, rst;
	logic [63:0] dnpc;
	logic        pc_update, ready_if_id;
	logic        valid_if_id, branch_flush;
	logic [63:0] pc;
	logic [31:0] inst;
	logic        ld_req, ld_busy, ld_done;
	logic [2:0]  ld_op;
	logic [63:0] ld_addr, ld_data;
	logic        wr_en;
	logic [63:0] wr_addr, wr_data;

	// copy of the preloaded memory
	logic [63:0]           image [mem_words];
	// model state
	logic [63:0]           exp_pc;
	fetch_pkg::lsu_state_e m_state;
	logic [2:0]            m_op;
	logic [63:0]           m_addr;
	logic [15:0]           lfsr = 16'd58;
	int                    n_checks = 0;
	int                    n_errors = 0;

	`include "tb_model.svh"

	fetch_top #(
		.reset_pc (reset_pc),
		.mem_words(mem_words)
	) dut0 (
		.clk(clk), .rst(rst), .dnpc(dnpc), .pc_update(pc_update),
		.ready_if_id(ready_if_id), .valid_if_id(valid_if_id), .pc(pc), .inst(inst),
		.branch_flush(branch_flush), .ld_req(ld_req), .ld_op(ld_op), .ld_addr(ld_addr),
		.ld_busy(ld_busy), .ld_done(ld_done), .ld_data(ld_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ******************************
	// helpers
	// ******************************

	function automatic int word_index(input logic [63:0] a);
		return int'(a[idx_w+2:3]);
	endfunction

	// background data mixing every address bit
	function automatic logic [63:0] fill_word(input logic [63:0] a);
		return {a[31:0] ^ a[63:32] ^ 32'h3c5a_9600, ~a[31:0] + a[63:32]};
	endfunction

	task automatic put_inst(input logic [63:0] a, input logic [31:0] v);
		if (a[2]) image[word_index(a)][63:32] = v;
		else image[word_index(a)][31:0] = v;
	endtask

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, want);
		end
	endtask

	// one lfsr step per bit
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// inputs move 2 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// hold > 1 sends more requests with other data while busy
	task automatic run_load(input logic [2:0] op, input logic [63:0] a, input int hold);
		int waited;
		ld_req  = 1'b1;
		ld_op   = op;
		ld_addr = a;
		next_cycle();
		// a busy lsu must not take these
		for (int i = 1; i < hold; i++) begin
			ld_op   = op ^ 3'd1;
			ld_addr = a ^ 64'h4d;
			next_cycle();
		end
		ld_req = 1'b0;
		waited = hold;
		while (!ld_done && waited < 8) begin
			next_cycle();
			waited++;
		end
		if (!ld_done) begin
			n_errors++;
			$display("load at %h never raised ld_done", a);
		end
		next_cycle();
	endtask

	// ******************************
	// checking process
	// ******************************

	initial begin : compare
		logic [63:0] word;
		logic [31:0] exp_inst;
		logic        exp_valid;
		forever begin
			@(negedge clk);
			if (rst) begin
				exp_pc  = reset_pc;
				m_state = fetch_pkg::idle;
			end else begin
				// lsu owns the port in its access cycle
				exp_valid = (m_state != fetch_pkg::access);
				word      = image[word_index(exp_pc)];
				exp_inst  = exp_pc[2] ? word[63:32] : word[31:0];
				check("pc", pc, exp_pc);
				check("valid_if_id", 64'(valid_if_id), 64'(exp_valid));
				if (exp_valid) check("inst", 64'(inst), 64'(exp_inst));
				check("branch_flush", 64'(branch_flush), 64'(pc_update));
				check("ld_busy", 64'(ld_busy), 64'(m_state != fetch_pkg::idle));
				check("ld_done", 64'(ld_done), 64'(m_state == fetch_pkg::done));
				if (m_state == fetch_pkg::done)
					check("ld_data", ld_data, ref_load(image[word_index(m_addr)], m_addr, m_op));
				// advance to the next edge
				exp_pc = ref_next_pc(exp_pc, exp_inst, pc_update, dnpc,
					!ready_if_id || !exp_valid);
				case (m_state)
					fetch_pkg::idle: begin
						if (ld_req) begin
							m_state = fetch_pkg::access;
							m_op    = ld_op;
							m_addr  = ld_addr;
						end
					end
					fetch_pkg::access: m_state = fetch_pkg::done;
					default:           m_state = fetch_pkg::idle;
				endcase
			end
		end
	end

	initial begin : watchdog
		#(n_cycles * clk_period + 4000);
		$display("timeout: run did not finish in the expected number of cycles");
		$display("checks %0d errors %0d", n_checks, n_errors);
		$display("Something failed");
		$finish;
	end

	// ******************************
	// stimulus
	// ******************************

	initial begin : stimulus
		logic [31:0] r;
		rst = 1'b1;
		dnpc = '0;
		pc_update = 1'b0;
		ready_if_id = 1'b1;
		ld_req = 1'b0;
		ld_op = '0;
		ld_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		for (int i = 0; i < mem_words; i++) image[i] = fill_word(reset_pc + 64'(i * 8));
		// loop over 0x00..0x10 where the forward beq falls through and the bne goes back
		put_inst(reset_pc + 64'h00, 32'h0000_0013);
		put_inst(reset_pc + 64'h04, 32'h0000_0013);
		put_inst(reset_pc + 64'h08, 32'h0000_0463);
		put_inst(reset_pc + 64'h0c, 32'h0000_0013);
		put_inst(reset_pc + 64'h10, 32'hfe00_18e3);
		// backward jal loop
		put_inst(reset_pc + 64'h40, 32'h0000_0013);
		put_inst(reset_pc + 64'h44, 32'hffdf_f06f);
		// backward beq loop
		put_inst(reset_pc + 64'h80, 32'h0000_0013);
		put_inst(reset_pc + 64'h84, 32'hfe00_0ee3);
		// preload while in reset
		for (int i = 0; i < mem_words; i++) begin
			wr_en   = 1'b1;
			wr_addr = reset_pc + 64'(i * 8);
			wr_data = image[i];
			next_cycle();
		end
		wr_en = 1'b0;
		repeat (2) next_cycle();
		rst = 1'b0;

		// sequential fetch and prediction
		repeat (14) next_cycle();
		// back-pressure
		ready_if_id = 1'b0;
		repeat (4) next_cycle();
		ready_if_id = 1'b1;
		repeat (2) next_cycle();
		// redirect beats the stall
		ready_if_id = 1'b0;
		pc_update   = 1'b1;
		dnpc        = reset_pc + 64'h40;
		next_cycle();
		pc_update   = 1'b0;
		ready_if_id = 1'b1;
		repeat (6) next_cycle();
		pc_update = 1'b1;
		dnpc      = reset_pc + 64'h80;
		next_cycle();
		pc_update = 1'b0;
		repeat (6) next_cycle();

		// every op at a few offsets with the last one repeated while busy
		for (int op = 0; op < 7; op++)
			for (int k = 0; k < 4; k++)
				run_load(3'(op), 64'h8000_0200 + 64'(op * 24 + k * 3), (k == 3) ? 2 : 1);

		// random mix of stalls, redirects and loads
		for (int c = 0; c < n_random; c++) begin
			rand_bits(2, r);
			ready_if_id = (r[1:0] != 2'b00);
			rand_bits(4, r);
			pc_update = (r[3:0] == 4'd0);
			rand_bits(6, r);
			dnpc = reset_pc + 64'({r[5:0], 2'b00});
			rand_bits(3, r);
			ld_req = (r[2:0] == 3'd0);
			rand_bits(3, r);
			ld_op = (r[2:0] == 3'd7) ? 3'd3 : r[2:0];
			rand_bits(11, r);
			ld_addr = reset_pc + 64'(r[10:0]);
			next_cycle();
		end
		pc_update = 1'b0;
		ld_req    = 1'b0;
		repeat (4) next_cycle();

		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
design/fetch_pkg.sv
design/mem_if.sv
design/ifu.sv
design/lsu.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/fetch_top.sv
testbench/tb_fetch.sv

//--- run.sh
#!/bin/sh
# build and run the fetch stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_fetch \
	-f flist.f -Mdir obj_dir -o tb_fetch_sim

out=$(./obj_dir/tb_fetch_sim)
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
